/* nn_top.f */
+incdir+sim
source/nn_cfg_pkg.sv
source/nn_types_pkg.sv
source/mac_if.sv
source/feature_mem.sv
source/param_mem.sv
source/mac_unit.sv
source/argmax_unit.sv
source/layer_sequencer.sv
source/nn_top.sv
sim/nn_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module nn_tb -f nn_top.f -o nn_sim
if ./obj_dir/nn_sim > sim.log 2>&1; then :; fi
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/nn_ref_model.svh */
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

// Golden model of the 8-4-4 network over feat_img and param_img

// Shift, clamp to int8, then ReLU if asked
function automatic int requantize(input int acc, input bit relu);
    int v;
    v = acc >>> REQUANT_SHIFT;
    if (v > 127) begin
        v = 127;
    end else if (v < -128) begin
        v = -128;
    end
    if (relu && v < 0) begin
        v = 0;
    end
    return v;
endfunction

// Signed value of lane k
function automatic int lane_value(input quad_t q, input int k);
    return int'(q.lane[k]);
endfunction

function automatic class_t predict_class();
    int hidden [HID_SIZE];
    int score [OUT_SIZE];
    int acc;
    int best;
    // Hidden layer, neuron n reads weight words 2n and 2n+1
    for (int n = 0; n < HID_SIZE; n++) begin
        acc = lane_value(param_img[int'(B0_BASE)], n);
        for (int w = 0; w < IN_WORDS; w++) begin
            for (int k = 0; k < LANES; k++) begin
                acc += lane_value(feat_img[int'(INPUT_BASE) + w], k)
                     * lane_value(param_img[int'(W0_BASE) + n * IN_WORDS + w], k);
            end
        end
        hidden[n] = requantize(acc, 1'b1);
    end
    // Output layer, one weight word per neuron, no ReLU
    for (int n = 0; n < OUT_SIZE; n++) begin
        acc = lane_value(param_img[int'(B1_BASE)], n);
        for (int k = 0; k < HID_SIZE; k++) begin
            acc += hidden[k] * lane_value(param_img[int'(W1_BASE) + n], k);
        end
        score[n] = requantize(acc, 1'b0);
    end
    // Strictly greater, so the lowest index keeps a tie
    best = 0;
    for (int n = 1; n < OUT_SIZE; n++) begin
        if (score[n] > score[best]) begin
            best = n;
        end
    end
    return class_t'(best);
endfunction

`endif

/* sim/nn_tb.sv */
`default_nettype none

module nn_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_RUNS     = 20;
    // Run bound of about 80 cycles, plus 18 load words and idle gaps
    localparam int RUN_BUDGET   = 125;
    localparam int MAX_CYCLES   = 2 * NUM_RUNS * RUN_BUDGET;

    logic                clk;
    logic                rstn;
    logic                r_valid;
    logic                load_en;
    logic                load_sel;
    logic [PARAM_AW-1:0] load_addr;
    logic [WORD_W-1:0]   load_data;
    class_t              out_data;
    logic                t_valid;

    // What the DUT memories are expected to hold
    quad_t       feat_img [FEAT_DEPTH];
    quad_t       param_img [PARAM_DEPTH];
    logic [31:0] rng_state;
    class_t      want_class;
    logic        run_started;
    int          cycle_count = 0;

    `include "nn_ref_model.svh"

    nn_top u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .r_valid   (r_valid),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_data  (out_data),
        .t_valid   (t_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", cycle_count);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Outputs stay quiet until the first start
    quiet_check: assert property (@(posedge clk) disable iff (!rstn)
        !run_started |-> (!t_valid && out_data == '0))
    else begin
        $display("FAIL t_valid = %h out_data = %h, expected 0 and 0", t_valid, out_data);
        stop_on_failure();
    end

    class_check: assert property (@(posedge clk) disable iff (!rstn)
        $rose(t_valid) |-> (out_data == want_class))
    else begin
        $display("FAIL out_data = %h, expected %h", out_data, want_class);
        stop_on_failure();
    end

    // Result held until the next accepted start
    hold_check: assert property (@(posedge clk) disable iff (!rstn)
        (t_valid && !r_valid) |=> (t_valid && $stable(out_data)))
    else begin
        $display("FAIL t_valid = %h out_data = %h, expected 1 and unchanged",
                 t_valid, out_data);
        stop_on_failure();
    end

    fall_check: assert property (@(posedge clk) disable iff (!rstn)
        (t_valid && r_valid) |=> !t_valid)
    else begin
        $display("FAIL t_valid = %h, expected 0 after start", t_valid);
        stop_on_failure();
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic load_word(input logic sel, input int addr, input logic [WORD_W-1:0] data);
        load_en   = 1'b1;
        load_sel  = sel;
        load_addr = PARAM_AW'(addr);
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic load_features();
        for (int w = 0; w < IN_WORDS; w++) begin
            load_word(1'b0, int'(INPUT_BASE) + w, feat_img[int'(INPUT_BASE) + w].raw);
        end
    endtask

    task automatic load_params();
        for (int a = 0; a < PARAM_DEPTH; a++) begin
            load_word(1'b1, a, param_img[a].raw);
        end
    endtask

    task automatic random_features();
        for (int w = 0; w < IN_WORDS; w++) begin
            feat_img[int'(INPUT_BASE) + w].raw = next_random();
        end
    endtask

    task automatic random_network();
        random_features();
        for (int a = 0; a < PARAM_DEPTH; a++) begin
            param_img[a].raw = next_random();
        end
    endtask

    // Max inputs times -128 weights, every hidden sum far below zero
    task automatic negative_hidden(input logic [WORD_W-1:0] out_bias);
        for (int w = 0; w < IN_WORDS; w++) begin
            feat_img[int'(INPUT_BASE) + w].raw = 32'h7F7F7F7F;
        end
        for (int i = 0; i < HID_SIZE * IN_WORDS; i++) begin
            param_img[int'(W0_BASE) + i].raw = 32'h80808080;
        end
        param_img[int'(B0_BASE)].raw = '0;
        for (int n = 0; n < OUT_SIZE; n++) begin
            param_img[int'(W1_BASE) + n].raw = next_random();
        end
        param_img[int'(B1_BASE)].raw = out_bias;
    endtask

    // Hidden values clamp to 127, neurons 1 and 2 both clamp to 127 too
    task automatic saturating_network();
        for (int w = 0; w < IN_WORDS; w++) begin
            feat_img[int'(INPUT_BASE) + w].raw = 32'h7F7F7F7F;
        end
        for (int i = 0; i < HID_SIZE * IN_WORDS; i++) begin
            param_img[int'(W0_BASE) + i].raw = 32'h7F7F7F7F;
        end
        param_img[int'(B0_BASE)].raw = '0;
        param_img[int'(W1_BASE) + 0].raw = 32'h01010101;
        param_img[int'(W1_BASE) + 1].raw = 32'h40404040;
        param_img[int'(W1_BASE) + 2].raw = 32'h7F7F7F7F;
        param_img[int'(W1_BASE) + 3].raw = 32'h80808080;
        param_img[int'(B1_BASE)].raw = '0;
    endtask

    task automatic wait_result();
        while (!t_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic run_network(input class_t expected);
        want_class  = expected;
        run_started = 1'b1;
        r_valid     = 1'b1;
        @(negedge clk);
        r_valid = 1'b0;
        wait_result();
    endtask

    // Extra start and a weight write while busy, both must be ignored
    task automatic run_with_interference();
        want_class  = predict_class();
        run_started = 1'b1;
        r_valid     = 1'b1;
        @(negedge clk);
        r_valid = 1'b0;
        repeat (4) @(negedge clk);
        r_valid = 1'b1;
        @(negedge clk);
        r_valid = 1'b0;
        repeat (4) @(negedge clk);
        load_word(1'b1, int'(W1_BASE), ~param_img[int'(W1_BASE)].raw);
        wait_result();
    endtask

    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        r_valid     = 1'b0;
        load_en     = 1'b0;
        load_sel    = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        run_started = 1'b0;
        want_class  = '0;
        rng_state   = 32'd47038;
        for (int i = 0; i < FEAT_DEPTH; i++) begin
            feat_img[i].raw = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);

        repeat (12) begin
            random_network();
            load_features();
            load_params();
            run_network(predict_class());
            repeat (2) @(negedge clk);
        end

        // Hidden all zero, scores -2 0 1 0
        negative_hidden(32'h007F3F80);
        load_features();
        load_params();
        run_network(class_t'(2));

        saturating_network();
        load_features();
        load_params();
        run_network(class_t'(1));

        // Equal output biases, all scores 1
        negative_hidden(32'h50505050);
        load_features();
        load_params();
        run_network(class_t'(0));

        random_network();
        load_features();
        load_params();
        run_with_interference();
        repeat (5) @(negedge clk);

        // Parameters kept from the run above
        repeat (4) begin
            random_features();
            load_features();
            run_network(predict_class());
        end
        repeat (3) @(negedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/nn_top.sv */
`default_nettype none

module nn_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              r_valid,
    input  logic                              load_en,
    input  logic                              load_sel,
    input  logic [nn_cfg_pkg::PARAM_AW-1:0]   load_addr,
    input  logic [nn_cfg_pkg::WORD_W-1:0]     load_data,
    output nn_types_pkg::class_t              out_data,
    output logic                              t_valid
);

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    quad_t               load_quad;
    logic                feat_wr_en;
    logic [FEAT_AW-1:0]  feat_wr_addr;
    quad_t               feat_wr_data;
    logic                feat_rd_en;
    logic [FEAT_AW-1:0]  feat_rd_addr;
    quad_t               feat_rd_data;
    logic                param_wr_en;
    logic                param_rd_en;
    logic [PARAM_AW-1:0] param_rd_addr;
    quad_t               param_rd_data;
    logic                arg_clear;
    logic                scores_valid;
    quad_t               scores;

    assign load_quad.raw = load_data;

    mac_if mac_bus ();

    feature_mem u_feature_mem (
        .clk     (clk),
        .wr_en   (feat_wr_en),
        .wr_addr (feat_wr_addr),
        .wr_data (feat_wr_data),
        .rd_en   (feat_rd_en),
        .rd_addr (feat_rd_addr),
        .rd_data (feat_rd_data)
    );

    // Parameter writes come straight from the load port
    param_mem u_param_mem (
        .clk     (clk),
        .wr_en   (param_wr_en),
        .wr_addr (load_addr),
        .wr_data (load_quad),
        .rd_en   (param_rd_en),
        .rd_addr (param_rd_addr),
        .rd_data (param_rd_data)
    );

    layer_sequencer u_sequencer (
        .clk           (clk),
        .rstn          (rstn),
        .start         (r_valid),
        .load_en       (load_en),
        .load_sel      (load_sel),
        .load_addr     (load_addr),
        .load_data     (load_quad),
        .feat_wr_en    (feat_wr_en),
        .feat_wr_addr  (feat_wr_addr),
        .feat_wr_data  (feat_wr_data),
        .feat_rd_en    (feat_rd_en),
        .feat_rd_addr  (feat_rd_addr),
        .feat_rd_data  (feat_rd_data),
        .param_wr_en   (param_wr_en),
        .param_rd_en   (param_rd_en),
        .param_rd_addr (param_rd_addr),
        .param_rd_data (param_rd_data),
        .mac           (mac_bus.seq),
        .arg_clear     (arg_clear),
        .scores_valid  (scores_valid),
        .scores        (scores),
        .busy          ()
    );

    mac_unit u_mac (
        .clk  (clk),
        .rstn (rstn),
        .bus  (mac_bus.mac)
    );

    // t_valid is the argmax result flag
    argmax_unit u_argmax (
        .clk          (clk),
        .rstn         (rstn),
        .clear        (arg_clear),
        .scores_valid (scores_valid),
        .scores       (scores),
        .class_out    (out_data),
        .result_valid (t_valid)
    );

endmodule

`default_nettype wire

/* source/layer_sequencer.sv */
`default_nettype none

module layer_sequencer (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start,
    input  logic                              load_en,
    input  logic                              load_sel,
    input  logic [nn_cfg_pkg::PARAM_AW-1:0]   load_addr,
    input  nn_types_pkg::quad_t               load_data,
    output logic                              feat_wr_en,
    output logic [nn_cfg_pkg::FEAT_AW-1:0]    feat_wr_addr,
    output nn_types_pkg::quad_t               feat_wr_data,
    output logic                              feat_rd_en,
    output logic [nn_cfg_pkg::FEAT_AW-1:0]    feat_rd_addr,
    input  nn_types_pkg::quad_t               feat_rd_data,
    output logic                              param_wr_en,
    output logic                              param_rd_en,
    output logic [nn_cfg_pkg::PARAM_AW-1:0]   param_rd_addr,
    input  nn_types_pkg::quad_t               param_rd_data,
    mac_if.seq                                mac,
    output logic                              arg_clear,
    output logic                              scores_valid,
    output nn_types_pkg::quad_t               scores,
    output logic                              busy
);

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_BIAS,
        S_COLLECT
    } state_t;

    state_t              state;
    logic                layer;
    lane_idx_t           neuron;
    logic [FEAT_AW-1:0]  word_cnt;
    logic                fetch_d;
    logic                bias_d;
    quad_t               collect_q;
    quad_t               collect_next;
    logic                last_word;
    logic                last_neuron;
    logic                neuron_done;
    logic                hidden_wb;
    logic [FEAT_AW-1:0]  feat_base;
    logic [PARAM_AW-1:0] weight_addr;
    logic [PARAM_AW-1:0] bias_addr;

    assign busy      = (state != S_IDLE);
    assign arg_clear = start && !busy;

    // Layer 0 walks IN_WORDS words per neuron, layer 1 the hidden quad
    assign last_word = layer ? (word_cnt == FEAT_AW'(HID_SIZE / LANES - 1))
                             : (word_cnt == FEAT_AW'(IN_WORDS - 1));
    // Each layer fills exactly one result quad
    assign last_neuron = (neuron == lane_idx_t'(LANES - 1));
    assign neuron_done = (state == S_COLLECT) && mac.done;

    // Address generation
    assign feat_base = layer ? HIDDEN_BASE : INPUT_BASE;
    assign weight_addr = layer
        ? W1_BASE + PARAM_AW'(neuron) * PARAM_AW'(HID_SIZE / LANES) + PARAM_AW'(word_cnt)
        : W0_BASE + PARAM_AW'(neuron) * PARAM_AW'(IN_WORDS) + PARAM_AW'(word_cnt);
    assign bias_addr = layer ? B1_BASE : B0_BASE;

    assign feat_rd_en    = (state == S_FETCH);
    assign feat_rd_addr  = feat_base + word_cnt;
    assign param_rd_en   = (state == S_FETCH) || (state == S_BIAS);
    assign param_rd_addr = (state == S_BIAS) ? bias_addr : weight_addr;

    // Operands show up one cycle after the paired reads
    assign mac.clear   = (state == S_FETCH) && (word_cnt == '0);
    assign mac.acc_en  = fetch_d;
    assign mac.feature = feat_rd_data;
    assign mac.weight  = param_rd_data;
    assign mac.bias_en = bias_d;
    assign mac.bias    = param_rd_data.lane[neuron];
    assign mac.relu    = !layer;

    // Result quad including the neuron that just finished
    always_comb begin
        collect_next              = collect_q;
        collect_next.lane[neuron] = mac.result;
    end

    assign hidden_wb = neuron_done && last_neuron && !layer;

    // Load port writes only while idle, hidden writeback otherwise
    assign feat_wr_en   = busy ? hidden_wb : (load_en && !load_sel);
    assign feat_wr_addr = busy ? HIDDEN_BASE : load_addr[FEAT_AW-1:0];
    assign feat_wr_data = busy ? collect_next : load_data;
    assign param_wr_en  = !busy && load_en && load_sel;

    assign scores_valid = neuron_done && last_neuron && layer;
    assign scores       = collect_next;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= S_IDLE;
            layer    <= 1'b0;
            neuron   <= '0;
            word_cnt <= '0;
            fetch_d  <= 1'b0;
            bias_d   <= 1'b0;
        end else begin
            // Match the read latency
            fetch_d <= (state == S_FETCH);
            bias_d  <= (state == S_BIAS);
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_FETCH;
                        layer    <= 1'b0;
                        neuron   <= '0;
                        word_cnt <= '0;
                    end
                end
                S_FETCH: begin
                    if (last_word) begin
                        word_cnt <= '0;
                        state    <= S_BIAS;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                S_BIAS: begin
                    state <= S_COLLECT;
                end
                S_COLLECT: begin
                    if (mac.done) begin
                        if (!last_neuron) begin
                            neuron <= neuron + 1'b1;
                            state  <= S_FETCH;
                        end else if (!layer) begin
                            // Hidden quad written this cycle, output layer next
                            layer  <= 1'b1;
                            neuron <= '0;
                            state  <= S_FETCH;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (neuron_done) begin
            collect_q <= collect_next;
        end
    end

endmodule

`default_nettype wire

/* source/argmax_unit.sv */
`default_nettype none

module argmax_unit (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clear,
    input  logic                   scores_valid,
    input  nn_types_pkg::quad_t    scores,
    output nn_types_pkg::class_t   class_out,
    output logic                   result_valid
);

    import nn_types_pkg::*;

    int8_t  left_val;
    int8_t  right_val;
    class_t left_idx;
    class_t right_idx;
    class_t best_idx;

    // Two-level tree, >= keeps the lower index on ties
    always_comb begin
        if (scores.lane[0] >= scores.lane[1]) begin
            left_val = scores.lane[0];
            left_idx = 2'd0;
        end else begin
            left_val = scores.lane[1];
            left_idx = 2'd1;
        end
        if (scores.lane[2] >= scores.lane[3]) begin
            right_val = scores.lane[2];
            right_idx = 2'd2;
        end else begin
            right_val = scores.lane[3];
            right_idx = 2'd3;
        end
        best_idx = (left_val >= right_val) ? left_idx : right_idx;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            class_out    <= '0;
            result_valid <= 1'b0;
        end else if (clear) begin
            result_valid <= 1'b0;
        end else if (scores_valid) begin
            class_out    <= best_idx;
            result_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/mac_unit.sv */
`default_nettype none

module mac_unit (
    input logic clk,
    input logic rstn,
    mac_if.mac  bus
);

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] lane_sum;
    logic signed [ACC_W-1:0] biased;
    logic signed [ACC_W-1:0] shifted;
    int8_t                   saturated;
    int8_t                   activated;

    // Four lane products of one word pair
    always_comb begin
        lane_sum = '0;
        for (int k = 0; k < LANES; k++) begin
            lane_sum = lane_sum + bus.feature.lane[k] * bus.weight.lane[k];
        end
    end

    assign biased  = acc + bus.bias;
    assign shifted = biased >>> REQUANT_SHIFT;

    // Clamp to int8 range
    always_comb begin
        if (shifted > 127) begin
            saturated = 8'sd127;
        end else if (shifted < -128) begin
            saturated = -8'sd128;
        end else begin
            saturated = shifted[BYTE_W-1:0];
        end
    end

    // ReLU for hidden neurons only
    assign activated = (bus.relu && saturated < 0) ? '0 : saturated;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.bias_en;
            if (bus.clear) begin
                acc <= '0;
            end else if (bus.acc_en) begin
                acc <= acc + lane_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.bias_en) begin
            bus.result <= activated;
        end
    end

endmodule

`default_nettype wire

/* source/param_mem.sv */
`default_nettype none

module param_mem (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [nn_cfg_pkg::PARAM_AW-1:0]   wr_addr,
    input  nn_types_pkg::quad_t               wr_data,
    input  logic                              rd_en,
    input  logic [nn_cfg_pkg::PARAM_AW-1:0]   rd_addr,
    output nn_types_pkg::quad_t               rd_data
);

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    quad_t               mem [PARAM_DEPTH];
    logic [PARAM_AW-1:0] addr;

    // Single shared address, write takes it
    assign addr = wr_en ? wr_addr : rd_addr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end else if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* source/feature_mem.sv */
`default_nettype none

module feature_mem (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [nn_cfg_pkg::FEAT_AW-1:0]   wr_addr,
    input  nn_types_pkg::quad_t              wr_data,
    input  logic                             rd_en,
    input  logic [nn_cfg_pkg::FEAT_AW-1:0]   rd_addr,
    output nn_types_pkg::quad_t              rd_data
);

    import nn_cfg_pkg::*;
    import nn_types_pkg::*;

    // Input vector and hidden results share this array
    quad_t mem [FEAT_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* source/mac_if.sv */
`default_nettype none

interface mac_if;

    logic                clear;
    logic                acc_en;
    nn_types_pkg::quad_t feature;
    nn_types_pkg::quad_t weight;
    logic                bias_en;
    nn_types_pkg::int8_t bias;
    logic                relu;

    // Returned by the MAC
    nn_types_pkg::int8_t result;
    logic                done;

    modport seq (
        output clear, acc_en, feature, weight, bias_en, bias, relu,
        input  result, done
    );

    modport mac (
        input  clear, acc_en, feature, weight, bias_en, bias, relu,
        output result, done
    );

endinterface

`default_nettype wire

/* source/nn_types_pkg.sv */
`default_nettype none

package nn_types_pkg;

    import nn_cfg_pkg::*;

    typedef logic signed [BYTE_W-1:0] int8_t;

    // One memory word, raw or as four int8 lanes (lane k at bits 8k+7:8k)
    typedef union packed {
        logic [WORD_W-1:0]    raw;
        int8_t [LANES-1:0]    lane;
    } quad_t;

    typedef logic [$clog2(LANES)-1:0] lane_idx_t;

    typedef logic [$clog2(OUT_SIZE)-1:0] class_t;

endpackage

`default_nettype wire

/* source/nn_cfg_pkg.sv */
`default_nettype none

package nn_cfg_pkg;

    // Word layout
    localparam int LANES  = 4;
    localparam int BYTE_W = 8;
    localparam int WORD_W = LANES * BYTE_W;

    // Network shape 8-4-4
    localparam int IN_SIZE  = 8;
    localparam int HID_SIZE = 4;
    localparam int OUT_SIZE = 4;
    localparam int IN_WORDS = IN_SIZE / LANES;

    // Memory sizes
    localparam int FEAT_DEPTH  = 4;
    localparam int FEAT_AW     = $clog2(FEAT_DEPTH);
    localparam int PARAM_DEPTH = 16;
    localparam int PARAM_AW    = $clog2(PARAM_DEPTH);

    // Feature memory map
    localparam logic [FEAT_AW-1:0] INPUT_BASE  = FEAT_AW'(0);
    localparam logic [FEAT_AW-1:0] HIDDEN_BASE = FEAT_AW'(2);

    // Parameter memory map, weights row by row per neuron
    localparam logic [PARAM_AW-1:0] W0_BASE = PARAM_AW'(0);
    localparam logic [PARAM_AW-1:0] B0_BASE = PARAM_AW'(8);
    localparam logic [PARAM_AW-1:0] W1_BASE = PARAM_AW'(9);
    localparam logic [PARAM_AW-1:0] B1_BASE = PARAM_AW'(13);

    // Arithmetic
    localparam int ACC_W         = 20;
    localparam int REQUANT_SHIFT = 6;

endpackage

`default_nettype wire
